// ==== common/rdmux_pkg.sv ====
package rdmux_pkg;

  // --------------------------------------------------------------------------
  // port count and field widths
  // --------------------------------------------------------------------------
  // completer ports behind the demux
  localparam int unsigned num_ports = 4;
  localparam int unsigned sel_w     = 2;
  // full axi id and the low part of it that indexes the counters
  localparam int unsigned id_w      = 4;
  localparam int unsigned look_bits = 2;
  localparam int unsigned num_cnt   = 2 ** look_bits;
  localparam int unsigned addr_w    = 32;
  localparam int unsigned data_w    = 32;
  // burst length field, beats minus one
  localparam int unsigned len_w     = 8;
  // in-flight counter, saturates (full) at all ones
  localparam int unsigned cnt_w     = 3;

  typedef logic [sel_w-1:0]     sel_t;
  typedef logic [id_w-1:0]      id_t;
  typedef logic [look_bits-1:0] look_t;
  typedef logic [addr_w-1:0]    addr_t;
  typedef logic [data_w-1:0]    data_t;
  typedef logic [len_w-1:0]     len_t;
  typedef logic [cnt_w-1:0]     cnt_t;

  // --------------------------------------------------------------------------
  // channel beats
  // --------------------------------------------------------------------------
  // read address beat, sel travels with the beat so it stays aligned
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    sel_t  sel;
  } ar_beat_t;

  // read data beat as returned to the requester
  typedef struct packed {
    id_t   id;
    data_t data;
    logic  last;
  } r_beat_t;

endpackage

// ==== common/ar_beat_if.sv ====
`timescale 1ns/1ps

// valid/ready link for one routed read address beat
interface ar_beat_if;

  // beat is offered while valid is high
  logic                valid;
  // consumer takes the beat when valid and ready meet on a clock edge
  logic                ready;
  rdmux_pkg::ar_beat_t beat;

  // producing side, holds beat stable until the transfer
  modport src (
    output valid,
    output beat,
    input  ready
  );

  // consuming side, may raise ready in reaction to valid
  modport dst (
    input  valid,
    input  beat,
    output ready
  );

endinterface

// ==== ar_path/rdmux_spill_reg.sv ====
`timescale 1ns/1ps

// two slot pipeline stage, all outputs come straight from flops
module rdmux_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,
  // upstream side
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  // downstream side
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // --------------------------------------------------------------------------
  // slot a takes new beats, slot b catches a beat the consumer refused
  // --------------------------------------------------------------------------
  logic a_full_q;
  logic b_full_q;
  T     a_data_q;
  T     b_data_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // new beat lands in a on every upstream transfer
  assign a_fill  = valid_i & ready_o;
  // a empties whenever b is free, either out the door or over into b
  assign a_drain = a_full_q & ~b_full_q;
  // a was offered but not taken, park it in b
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  // control flags
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  // payload slots
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // b always holds the older beat, so it goes first
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  // only both slots taken stops the producer
  assign ready_o = ~a_full_q | ~b_full_q;

endmodule

// ==== ar_path/rdmux_id_counters.sv ====
`timescale 1ns/1ps

// outstanding read bookkeeping per low id bits
module rdmux_id_counters (
  input  logic              clk_i,
  input  logic              arst_n_i,
  // lookup for the beat waiting at the ar stage
  input  rdmux_pkg::look_t  lookup_id_i,
  output rdmux_pkg::sel_t   lookup_sel_o,
  output logic              occupied_o,
  // any counter saturated
  output logic              full_o,
  // ar accepted by a port
  input  logic              push_i,
  input  rdmux_pkg::look_t  push_id_i,
  input  rdmux_pkg::sel_t   push_sel_i,
  // last r beat handed to the requester
  input  logic              pop_i,
  input  rdmux_pkg::look_t  pop_id_i
);

  // per counter status gathered from the generate slices
  rdmux_pkg::sel_t [rdmux_pkg::num_cnt-1:0] port_sel;
  logic [rdmux_pkg::num_cnt-1:0]            occupied;
  logic [rdmux_pkg::num_cnt-1:0]            cnt_full;

  // --------------------------------------------------------------------------
  // one counter and one remembered port per index
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < rdmux_pkg::num_cnt; i++) begin : gen_cnt
    logic             push_en;
    logic             pop_en;
    rdmux_pkg::cnt_t  in_flight_q;
    rdmux_pkg::sel_t  sel_q;

    assign push_en = push_i & (push_id_i == rdmux_pkg::look_t'(i));
    assign pop_en  = pop_i & (pop_id_i == rdmux_pkg::look_t'(i));

    // push and pop together leave the count as is
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        in_flight_q <= '0;
      end else if (push_en && !pop_en) begin
        in_flight_q <= in_flight_q + rdmux_pkg::cnt_t'(1);
      end else if (pop_en && !push_en) begin
        in_flight_q <= in_flight_q - rdmux_pkg::cnt_t'(1);
      end
    end

    // port of the most recent push, only meaningful while occupied
    always_ff @(posedge clk_i) begin
      if (push_en) begin
        sel_q <= push_sel_i;
      end
    end

    assign occupied[i] = |in_flight_q;
    assign cnt_full[i] = &in_flight_q;
    assign port_sel[i] = sel_q;
  end

  // --------------------------------------------------------------------------
  // lookup and global full
  // --------------------------------------------------------------------------
  assign lookup_sel_o = port_sel[lookup_id_i];
  assign occupied_o   = occupied[lookup_id_i];
  // stall everything once a single counter cannot take another push
  assign full_o       = |cnt_full;

endmodule

// ==== ar_path/rdmux_ar_ctrl.sv ====
`timescale 1ns/1ps

// decides when the waiting ar beat may go out and to which port
module rdmux_ar_ctrl (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // beat from the ar spill register
  ar_beat_if.dst                              ar,
  // completer ports
  output logic [rdmux_pkg::num_ports-1:0]     m_ar_valid_o,
  input  logic [rdmux_pkg::num_ports-1:0]     m_ar_ready_i,
  output rdmux_pkg::ar_beat_t                 m_ar_beat_o,
  // id counter interface
  output logic                                push_o,
  input  rdmux_pkg::sel_t                     lookup_sel_i,
  input  logic                                occupied_i,
  input  logic                                full_i
);

  // valid offered to the selected port
  logic ar_valid;
  // selected port took the beat
  logic ar_ready;
  // once offered the valid must stay up, even if counters change under it
  logic lock_d;
  logic lock_q;

  assign ar_ready = m_ar_ready_i[ar.beat.sel];

  // --------------------------------------------------------------------------
  // admission
  // --------------------------------------------------------------------------
  always_comb begin
    ar_valid = 1'b0;
    ar.ready = 1'b0;
    push_o   = 1'b0;
    lock_d   = lock_q;
    if (lock_q) begin
      // decision already made, just wait for the port
      ar_valid = 1'b1;
      if (ar_ready) begin
        ar.ready = 1'b1;
        push_o   = 1'b1;
        lock_d   = 1'b0;
      end
    end else if (!full_i) begin
      // same id only allowed while it targets the port already in use
      if (ar.valid && (!occupied_i || (lookup_sel_i == ar.beat.sel))) begin
        ar_valid = 1'b1;
        if (ar_ready) begin
          ar.ready = 1'b1;
          push_o   = 1'b1;
        end else begin
          lock_d = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // --------------------------------------------------------------------------
  // fan-out, payload to all ports and valid only to the selected one
  // --------------------------------------------------------------------------
  assign m_ar_beat_o = ar.beat;

  always_comb begin
    m_ar_valid_o = '0;
    for (int unsigned i = 0; i < rdmux_pkg::num_ports; i++) begin
      if (ar_valid && (ar.beat.sel == rdmux_pkg::sel_t'(i))) begin
        m_ar_valid_o[i] = 1'b1;
      end
    end
  end

endmodule

// ==== hdl/rdmux_r_arbiter.sv ====
`timescale 1ns/1ps

// round-robin merge of the port r streams, grant held while stalled
module rdmux_r_arbiter (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  // port side
  input  logic [rdmux_pkg::num_ports-1:0]             req_valid_i,
  output logic [rdmux_pkg::num_ports-1:0]             req_ready_o,
  input  rdmux_pkg::r_beat_t [rdmux_pkg::num_ports-1:0] req_beat_i,
  // merged output
  output logic                                        out_valid_o,
  input  logic                                        out_ready_i,
  output rdmux_pkg::r_beat_t                          out_beat_o
);

  // last port that got a beat through
  rdmux_pkg::sel_t rr_ptr_q;
  // lock-in on a stalled grant
  logic            lock_q;
  rdmux_pkg::sel_t lock_idx_q;

  rdmux_pkg::sel_t pick;
  rdmux_pkg::sel_t cand;
  rdmux_pkg::sel_t gnt_idx;
  logic            found;
  logic            xfer;

  // --------------------------------------------------------------------------
  // search starts one past the pointer and wraps around
  // --------------------------------------------------------------------------
  always_comb begin
    pick  = rr_ptr_q;
    cand  = rr_ptr_q;
    found = 1'b0;
    for (int unsigned k = 1; k <= rdmux_pkg::num_ports; k++) begin
      cand = rdmux_pkg::sel_t'((32'(rr_ptr_q) + k) % rdmux_pkg::num_ports);
      if (!found && req_valid_i[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  // stalled grant wins over a fresh pick
  assign gnt_idx     = lock_q ? lock_idx_q : pick;
  // no request anywhere leaves the pick on an idle port, so valid stays low
  assign out_valid_o = req_valid_i[gnt_idx];
  assign out_beat_o  = req_beat_i[gnt_idx];
  assign xfer        = out_valid_o & out_ready_i;

  always_comb begin
    req_ready_o          = '0;
    req_ready_o[gnt_idx] = xfer;
  end

  // --------------------------------------------------------------------------
  // pointer and lock
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // beat offered but not taken, keep this port
      lock_q     <= out_valid_o & ~out_ready_i;
      lock_idx_q <= gnt_idx;
      if (xfer) begin
        rr_ptr_q <= gnt_idx;
      end
    end
  end

endmodule

// ==== hdl/rdmux_top.sv ====
`timescale 1ns/1ps

// read path of a one to four axi demux
module rdmux_top (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  // requester ar
  input  logic                                          s_ar_valid_i,
  output logic                                          s_ar_ready_o,
  input  rdmux_pkg::id_t                                s_ar_id_i,
  input  rdmux_pkg::addr_t                              s_ar_addr_i,
  input  rdmux_pkg::len_t                               s_ar_len_i,
  input  rdmux_pkg::sel_t                               s_ar_sel_i,
  // requester r
  output logic                                          s_r_valid_o,
  input  logic                                          s_r_ready_i,
  output rdmux_pkg::id_t                                s_r_id_o,
  output rdmux_pkg::data_t                              s_r_data_o,
  output logic                                          s_r_last_o,
  // completer ar
  output logic             [rdmux_pkg::num_ports-1:0]   m_ar_valid_o,
  input  logic             [rdmux_pkg::num_ports-1:0]   m_ar_ready_i,
  output rdmux_pkg::id_t   [rdmux_pkg::num_ports-1:0]   m_ar_id_o,
  output rdmux_pkg::addr_t [rdmux_pkg::num_ports-1:0]   m_ar_addr_o,
  output rdmux_pkg::len_t  [rdmux_pkg::num_ports-1:0]   m_ar_len_o,
  // completer r
  input  logic             [rdmux_pkg::num_ports-1:0]   m_r_valid_i,
  output logic             [rdmux_pkg::num_ports-1:0]   m_r_ready_o,
  input  rdmux_pkg::id_t   [rdmux_pkg::num_ports-1:0]   m_r_id_i,
  input  rdmux_pkg::data_t [rdmux_pkg::num_ports-1:0]   m_r_data_i,
  input  logic             [rdmux_pkg::num_ports-1:0]   m_r_last_i
);

  // --------------------------------------------------------------------------
  // ar path
  // --------------------------------------------------------------------------
  rdmux_pkg::ar_beat_t s_ar_beat;
  rdmux_pkg::ar_beat_t m_ar_beat;
  logic                ar_push;
  rdmux_pkg::sel_t     lookup_sel;
  logic                id_occupied;
  logic                id_full;

  // per port r beats, the merged stream and the retire strobe
  rdmux_pkg::r_beat_t [rdmux_pkg::num_ports-1:0] m_r_beat;
  rdmux_pkg::r_beat_t                            r_arb_beat;
  rdmux_pkg::r_beat_t                            s_r_beat;
  logic                                          r_arb_valid;
  logic                                          r_arb_ready;
  logic                                          r_pop;

  // link between the ar spill register and the admission logic
  ar_beat_if ar_mid ();

  assign s_ar_beat = '{id: s_ar_id_i, addr: s_ar_addr_i, len: s_ar_len_i, sel: s_ar_sel_i};

  rdmux_spill_reg #(
    .T ( rdmux_pkg::ar_beat_t )
  ) i_ar_spill_reg (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .valid_i  ( s_ar_valid_i ),
    .ready_o  ( s_ar_ready_o ),
    .data_i   ( s_ar_beat    ),
    .valid_o  ( ar_mid.valid ),
    .ready_i  ( ar_mid.ready ),
    .data_o   ( ar_mid.beat  )
  );

  rdmux_ar_ctrl i_ar_ctrl (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .ar           ( ar_mid.dst   ),
    .m_ar_valid_o ( m_ar_valid_o ),
    .m_ar_ready_i ( m_ar_ready_i ),
    .m_ar_beat_o  ( m_ar_beat    ),
    .push_o       ( ar_push      ),
    .lookup_sel_i ( lookup_sel   ),
    .occupied_i   ( id_occupied  ),
    .full_i       ( id_full      )
  );

  // lookup and push both use the beat sitting at the admission stage
  rdmux_id_counters i_id_counters (
    .clk_i        ( clk_i                                      ),
    .arst_n_i     ( arst_n_i                                   ),
    .lookup_id_i  ( m_ar_beat.id[rdmux_pkg::look_bits-1:0]     ),
    .lookup_sel_o ( lookup_sel                                 ),
    .occupied_o   ( id_occupied                                ),
    .full_o       ( id_full                                    ),
    .push_i       ( ar_push                                    ),
    .push_id_i    ( m_ar_beat.id[rdmux_pkg::look_bits-1:0]     ),
    .push_sel_i   ( m_ar_beat.sel                              ),
    .pop_i        ( r_pop                                      ),
    .pop_id_i     ( s_r_beat.id[rdmux_pkg::look_bits-1:0]      )
  );

  // payload goes to every port and the valid alone picks one
  for (genvar i = 0; i < rdmux_pkg::num_ports; i++) begin : gen_ports
    assign m_ar_id_o[i]   = m_ar_beat.id;
    assign m_ar_addr_o[i] = m_ar_beat.addr;
    assign m_ar_len_o[i]  = m_ar_beat.len;
    assign m_r_beat[i]    = '{id: m_r_id_i[i], data: m_r_data_i[i], last: m_r_last_i[i]};
  end

  // --------------------------------------------------------------------------
  // r path
  // --------------------------------------------------------------------------
  rdmux_r_arbiter i_r_arbiter (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .req_valid_i ( m_r_valid_i ),
    .req_ready_o ( m_r_ready_o ),
    .req_beat_i  ( m_r_beat    ),
    .out_valid_o ( r_arb_valid ),
    .out_ready_i ( r_arb_ready ),
    .out_beat_o  ( r_arb_beat  )
  );

  rdmux_spill_reg #(
    .T ( rdmux_pkg::r_beat_t )
  ) i_r_spill_reg (
    .clk_i    ( clk_i       ),
    .arst_n_i ( arst_n_i    ),
    .valid_i  ( r_arb_valid ),
    .ready_o  ( r_arb_ready ),
    .data_i   ( r_arb_beat  ),
    .valid_o  ( s_r_valid_o ),
    .ready_i  ( s_r_ready_i ),
    .data_o   ( s_r_beat    )
  );

  assign s_r_id_o   = s_r_beat.id;
  assign s_r_data_o = s_r_beat.data;
  assign s_r_last_o = s_r_beat.last;
  // a read retires once its last beat has left towards the requester
  assign r_pop      = s_r_valid_o & s_r_ready_i & s_r_beat.last;

endmodule

// ==== bench/tb_rdmux.sv ====
`timescale 1ns/1ps

module tb_rdmux;

  // about four times the length of all tests together
  localparam int max_cycles = 2000;
  // marks a completion time that has not been seen yet
  localparam int idle_cyc   = 32'h7fffffff;

  logic clk_i;
  logic arst_n_i;
  logic s_ar_valid_i;
  logic s_ar_ready_o;
  rdmux_pkg::id_t   s_ar_id_i;
  rdmux_pkg::addr_t s_ar_addr_i;
  rdmux_pkg::len_t  s_ar_len_i;
  rdmux_pkg::sel_t  s_ar_sel_i;
  logic             s_r_valid_o;
  logic             s_r_ready_i;
  rdmux_pkg::id_t   s_r_id_o;
  rdmux_pkg::data_t s_r_data_o;
  logic             s_r_last_o;
  logic [rdmux_pkg::num_ports-1:0]             m_ar_valid_o;
  logic [rdmux_pkg::num_ports-1:0]             m_ar_ready_i;
  rdmux_pkg::id_t   [rdmux_pkg::num_ports-1:0] m_ar_id_o;
  rdmux_pkg::addr_t [rdmux_pkg::num_ports-1:0] m_ar_addr_o;
  rdmux_pkg::len_t  [rdmux_pkg::num_ports-1:0] m_ar_len_o;
  logic [rdmux_pkg::num_ports-1:0]             m_r_valid_i;
  logic [rdmux_pkg::num_ports-1:0]             m_r_ready_o;
  rdmux_pkg::id_t   [rdmux_pkg::num_ports-1:0] m_r_id_i;
  rdmux_pkg::data_t [rdmux_pkg::num_ports-1:0] m_r_data_i;
  logic [rdmux_pkg::num_ports-1:0]             m_r_last_i;

  // --------------------------------------------------------------------------
  // bench state
  // --------------------------------------------------------------------------
  integer seed;
  int     cyc;
  // ar beats sent by the requester and ar beats seen at the ports
  rdmux_pkg::ar_beat_t exp_ar_q[$];
  rdmux_pkg::ar_beat_t ar_log[$];
  int                  ar_cyc_q[$];
  // per port accepted reads still to answer and r beats handed over
  rdmux_pkg::ar_beat_t pend_q[rdmux_pkg::num_ports][$];
  rdmux_pkg::r_beat_t  sent_q[rdmux_pkg::num_ports][$];
  rdmux_pkg::r_beat_t  shown[rdmux_pkg::num_ports];
  int                  beat_idx[rdmux_pkg::num_ports];
  logic [rdmux_pkg::num_ports-1:0] r_taken;
  // completer and requester behavior knobs
  logic [rdmux_pkg::num_ports-1:0] hold;
  logic [rdmux_pkg::num_ports-1:0] ar_ready_en;
  logic stall_mode;
  int   stretch;
  // port of each beat at the requester and beat counts
  int out_port_q[$];
  int exp_cnt;
  int rcv_cnt;
  // cycle of the first last beat per id
  int last_cyc_id[16];

  rdmux_top i_rdmux_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // failure and compare tasks
  // --------------------------------------------------------------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_sel(input string name, input rdmux_pkg::sel_t exp,
                           input rdmux_pkg::sel_t act);
    if (act !== exp) begin
      report_failure($sformatf("** Error: %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_ar_beat(input string name, input rdmux_pkg::ar_beat_t exp,
                               input rdmux_pkg::ar_beat_t act);
    if (act !== exp) begin
      report_failure($sformatf("** Error: %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_r_beat(input string name, input rdmux_pkg::r_beat_t exp,
                              input rdmux_pkg::r_beat_t act);
    if (act !== exp) begin
      report_failure($sformatf("** Error: %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  // per port valid and ready vectors
  task automatic check_flags(input string name, input logic [rdmux_pkg::num_ports-1:0] exp,
                             input logic [rdmux_pkg::num_ports-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("** Error: %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  // --------------------------------------------------------------------------
  // handshake monitor sampling at the edge where transfers happen
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin : monitor
    rdmux_pkg::ar_beat_t seen;
    rdmux_pkg::r_beat_t  got;
    int                  hit;
    cyc++;
    if (cyc >= max_cycles) begin
      report_failure($sformatf("timeout, run did not finish within %0d cycles", max_cycles));
    end
    if (arst_n_i) begin
      if ($countones(m_ar_valid_o) > 1) begin
        report_failure("m_ar_valid_o is high on more than one port at once");
      end
      for (int p = 0; p < rdmux_pkg::num_ports; p++) begin
        if (m_ar_valid_o[p] && m_ar_ready_i[p]) begin
          seen = '{id: m_ar_id_o[p], addr: m_ar_addr_o[p], len: m_ar_len_o[p],
                   sel: rdmux_pkg::sel_t'(p)};
          ar_log.push_back(seen);
          ar_cyc_q.push_back(cyc);
          pend_q[p].push_back(seen);
        end
        if (m_r_valid_i[p] && m_r_ready_o[p]) begin
          sent_q[p].push_back(shown[p]);
          r_taken[p] = 1'b1;
        end
      end
      if (s_r_valid_o && s_r_ready_i) begin
        got = '{id: s_r_id_o, data: s_r_data_o, last: s_r_last_o};
        hit = -1;
        // only the oldest beat of each port may show up next
        for (int p = 0; p < rdmux_pkg::num_ports; p++) begin
          if (hit < 0 && sent_q[p].size() > 0 && sent_q[p][0].data == got.data) begin
            hit = p;
          end
        end
        if (hit < 0) begin
          report_failure($sformatf("R beat with data %h is not the next beat of any port",
                                   got.data));
        end
        check_r_beat("s_r beat", sent_q[hit][0], got);
        void'(sent_q[hit].pop_front());
        out_port_q.push_back(hit);
        rcv_cnt++;
        if (got.last && last_cyc_id[got.id] == idle_cyc) begin
          last_cyc_id[got.id] = cyc;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // completer models and requester ready driven on the falling edge
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin : drivers
    if (arst_n_i) begin
      for (int p = 0; p < rdmux_pkg::num_ports; p++) begin
        if (r_taken[p]) begin
          r_taken[p]     = 1'b0;
          m_r_valid_i[p] = 1'b0;
          if (beat_idx[p] == int'(pend_q[p][0].len)) begin
            void'(pend_q[p].pop_front());
            beat_idx[p] = 0;
          end else begin
            beat_idx[p]++;
          end
        end
        // a read answers with len+1 beats and marks the final one last
        if (!m_r_valid_i[p] && !hold[p] && pend_q[p].size() > 0) begin
          shown[p].id    = pend_q[p][0].id;
          shown[p].data  = $random(seed);
          shown[p].last  = (beat_idx[p] == int'(pend_q[p][0].len));
          m_r_valid_i[p] = 1'b1;
          m_r_id_i[p]    = shown[p].id;
          m_r_data_i[p]  = shown[p].data;
          m_r_last_i[p]  = shown[p].last;
        end
        m_ar_ready_i[p] = ar_ready_en[p];
      end
      // random stretches of ready low and high
      if (!stall_mode) begin
        s_r_ready_i = 1'b1;
      end else if (stretch == 0) begin
        s_r_ready_i = ~s_r_ready_i;
        stretch     = $unsigned($random(seed)) % 6;
      end else begin
        stretch--;
      end
    end
  end

  // --------------------------------------------------------------------------
  // helper tasks
  // --------------------------------------------------------------------------
  // knobs change on the rising edge so the models see them cleanly
  task automatic set_model(input logic [3:0] hold_v, input logic [3:0] ready_v,
                           input logic stall_v);
    @(posedge clk_i);
    hold        = hold_v;
    ar_ready_en = ready_v;
    stall_mode  = stall_v;
  endtask

  task automatic send_ar(input rdmux_pkg::id_t id, input rdmux_pkg::addr_t addr,
                         input rdmux_pkg::len_t len, input rdmux_pkg::sel_t sel);
    @(negedge clk_i);
    s_ar_valid_i = 1'b1;
    s_ar_id_i    = id;
    s_ar_addr_i  = addr;
    s_ar_len_i   = len;
    s_ar_sel_i   = sel;
    exp_ar_q.push_back('{id: id, addr: addr, len: len, sel: sel});
    exp_cnt += int'(len) + 1;
    @(posedge clk_i);
    while (!s_ar_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    s_ar_valid_i = 1'b0;
  endtask

  // next ar at a port must be the oldest one sent and sit on its selected port
  task automatic expect_ar(output int ar_cycle);
    rdmux_pkg::ar_beat_t exp;
    rdmux_pkg::ar_beat_t got;
    while (ar_log.size() == 0) @(negedge clk_i);
    exp      = exp_ar_q.pop_front();
    got      = ar_log.pop_front();
    ar_cycle = ar_cyc_q.pop_front();
    check_sel("m_ar port", exp.sel, got.sel);
    check_ar_beat("m_ar beat", exp, got);
  endtask

  task automatic wait_drain();
    while (rcv_cnt != exp_cnt) @(negedge clk_i);
    repeat (5) @(negedge clk_i);
    if (rcv_cnt != exp_cnt) begin
      report_failure($sformatf("got %0d R beats, reads asked for %0d", rcv_cnt, exp_cnt));
    end
    check_flags("s_r_valid_o", 4'b0000, {3'b000, s_r_valid_o});
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic route_after_reset();
    int when;
    check_flags("m_ar_valid_o", 4'b0000, m_ar_valid_o);
    check_flags("m_r_ready_o", 4'b0000, m_r_ready_o);
    check_flags("s_r_valid_o", 4'b0000, {3'b000, s_r_valid_o});
    check_flags("s_ar_ready_o", 4'b0001, {3'b000, s_ar_ready_o});
    for (int k = 0; k < rdmux_pkg::num_ports; k++) begin
      send_ar(rdmux_pkg::id_t'(k), 32'h1000_0040 + 32'(k) * 32'h100, 8'd0,
              rdmux_pkg::sel_t'(k));
      expect_ar(when);
    end
    wait_drain();
  endtask

  task automatic return_read_data();
    int when;
    send_ar(4'd4, 32'h2000_0000, 8'd3, 2'd0);
    expect_ar(when);
    send_ar(4'd7, 32'h2000_8000, 8'd7, 2'd2);
    expect_ar(when);
    wait_drain();
  endtask

  task automatic merge_round_robin();
    logic [3:0] used;
    int         when;
    used = '0;
    set_model(4'b1111, 4'b1111, 1'b0);
    for (int k = 0; k < rdmux_pkg::num_ports; k++) begin
      send_ar(rdmux_pkg::id_t'(8 + k), 32'h3000_0000 + 32'(k), 8'd1, rdmux_pkg::sel_t'(k));
      expect_ar(when);
    end
    out_port_q.delete();
    // all four ports raise valid in the same cycle
    set_model(4'b0000, 4'b1111, 1'b0);
    while (out_port_q.size() < 4) @(negedge clk_i);
    for (int i = 0; i < 4; i++) begin
      if (used[out_port_q[i]]) begin
        report_failure($sformatf("port %0d served twice in the first four R beats",
                                 out_port_q[i]));
      end
      used[out_port_q[i]] = 1'b1;
    end
    wait_drain();
  endtask

  task automatic order_same_id();
    int when;
    set_model(4'b0010, 4'b1111, 1'b0);
    last_cyc_id[5] = idle_cyc;
    send_ar(4'd5, 32'h4000_0000, 8'd1, 2'd1);
    expect_ar(when);
    // other id to another port is not held up
    send_ar(4'd6, 32'h4000_1000, 8'd0, 2'd3);
    expect_ar(when);
    send_ar(4'd5, 32'h4000_2000, 8'd0, 2'd2);
    repeat (10) @(negedge clk_i);
    if (ar_log.size() != 0) begin
      report_failure("read to port 2 passed while its id was outstanding at port 1");
    end
    check_flags("m_ar_valid_o", 4'b0000, m_ar_valid_o);
    set_model(4'b0000, 4'b1111, 1'b0);
    expect_ar(when);
    if (when <= last_cyc_id[5]) begin
      report_failure("read to port 2 left before the first read with its id completed");
    end
    wait_drain();
  endtask

  task automatic stall_on_full_counter();
    int when;
    set_model(4'b0001, 4'b1111, 1'b0);
    last_cyc_id[3] = idle_cyc;
    for (int k = 0; k < 7; k++) begin
      send_ar(4'd3, 32'h5000_0000 + 32'(k) * 32'h40, 8'd0, 2'd0);
      expect_ar(when);
    end
    // counter at 7 stalls every id
    send_ar(4'd1, 32'h5000_8000, 8'd0, 2'd1);
    repeat (10) @(negedge clk_i);
    if (ar_log.size() != 0) begin
      report_failure("eighth read reached a port while a counter was full");
    end
    check_flags("m_ar_valid_o", 4'b0000, m_ar_valid_o);
    set_model(4'b0000, 4'b1111, 1'b0);
    expect_ar(when);
    if (when <= last_cyc_id[3]) begin
      report_failure("eighth read left before any of the seven reads completed");
    end
    wait_drain();
  endtask

  task automatic hold_under_backpressure();
    rdmux_pkg::ar_beat_t held;
    rdmux_pkg::ar_beat_t now;
    int                  when;
    held = '{id: 4'd2, addr: 32'h6000_0000, len: 8'd0, sel: 2'd1};
    set_model(4'b0000, 4'b1101, 1'b0);
    send_ar(held.id, held.addr, held.len, held.sel);
    while (!m_ar_valid_o[1]) @(negedge clk_i);
    repeat (8) begin
      now = '{id: m_ar_id_o[1], addr: m_ar_addr_o[1], len: m_ar_len_o[1], sel: 2'd1};
      check_flags("m_ar_valid_o", 4'b0010, m_ar_valid_o);
      check_ar_beat("m_ar beat while stalled", held, now);
      @(negedge clk_i);
    end
    set_model(4'b0000, 4'b1111, 1'b0);
    expect_ar(when);
    wait_drain();
    // requester ready toggles in random stretches
    set_model(4'b0000, 4'b1111, 1'b1);
    for (int k = 0; k < rdmux_pkg::num_ports; k++) begin
      send_ar(rdmux_pkg::id_t'(12 + k), 32'h6100_0000 + 32'(k) * 32'h80, 8'd3,
              rdmux_pkg::sel_t'(k));
      expect_ar(when);
    end
    wait_drain();
    set_model(4'b0000, 4'b1111, 1'b0);
  endtask

  // --------------------------------------------------------------------------
  // sequence
  // --------------------------------------------------------------------------
  initial begin
    seed         = 32'h6987044c;
    cyc          = 0;
    arst_n_i     = 1'b0;
    s_ar_valid_i = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_ar_sel_i   = '0;
    s_r_ready_i  = 1'b1;
    m_ar_ready_i = '0;
    m_r_valid_i  = '0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_last_i   = '0;
    r_taken      = '0;
    hold         = '0;
    ar_ready_en  = 4'b1111;
    stall_mode   = 1'b0;
    stretch      = 0;
    exp_cnt      = 0;
    rcv_cnt      = 0;
    for (int i = 0; i < rdmux_pkg::num_ports; i++) begin
      beat_idx[i] = 0;
    end
    for (int i = 0; i < 16; i++) begin
      last_cyc_id[i] = idle_cyc;
    end
    repeat (4) @(negedge clk_i);
    arst_n_i = 1'b1;
    route_after_reset();
    return_read_data();
    merge_round_robin();
    order_same_id();
    stall_on_full_counter();
    hold_under_backpressure();
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== all.f ====
common/rdmux_pkg.sv
common/ar_beat_if.sv
ar_path/rdmux_spill_reg.sv
ar_path/rdmux_id_counters.sv
ar_path/rdmux_ar_ctrl.sv
hdl/rdmux_r_arbiter.sv
hdl/rdmux_top.sv
bench/tb_rdmux.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_rdmux
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
